// File: common/lsq_pkg.sv
// shared widths, queue depth, memory size and control states for the load/store queue
package lsq_pkg;

  // byte address as the core sends it
  typedef logic [31:0] addr_t;

  // one memory word, load result or store data
  typedef logic [31:0] word_t;

  // destination register tag carried along with each request
  typedef logic [3:0] dest_t;

  // queue slot index, also sent to memory as the request id
  typedef logic [3:0] lsq_id_t;

  // number of queue slots, ids 0 to 14
  localparam int LSQ_DEPTH = 15;

  // data memory size in words
  // word index comes from address bits 11..2
  localparam int MEM_WORDS = 1024;

  // issue control states
  // idle     nothing held
  // active   at least one entry still waits for issue
  // drain    everything issued, answers or retirements still pending
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACTIVE = 2'd1,
    DRAIN  = 2'd2
  } ctrl_state_t;

endpackage

// File: hw/lsq/lsq_ctrl.sv
// ring pointers, occupancy and unissued counts, issue FSM, retire and full/empty flags
`timescale 1ns/10ps

module lsq_ctrl import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    i_mem_rd,
  input  logic    i_mem_wr,
  input  logic    i_head_done,
  input  logic    i_stall,
  output logic    o_alloc,
  output lsq_id_t o_tail_id,
  output lsq_id_t o_issue_id,
  output lsq_id_t o_head_id,
  output logic    o_issue_valid,
  output logic    o_ret_valid,
  output logic    o_full,
  output logic    o_empty
);

  // counters must hold 0..DEPTH
  localparam int CW = $clog2(DEPTH + 1);

  lsq_id_t     tail_ptr;
  lsq_id_t     issue_ptr;
  lsq_id_t     head_ptr;
  logic [CW-1:0] count;
  logic [CW-1:0] count_nxt;
  logic [CW-1:0] unissued;
  logic [CW-1:0] unissued_nxt;
  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        accept;
  logic        issue;
  logic        retire;

  // ring increment, wraps after the last slot
  function automatic lsq_id_t ptr_inc(input lsq_id_t ptr);
    lsq_id_t nxt;
    if (ptr == lsq_id_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + lsq_id_t'(1);
    end
    return nxt;
  endfunction

  // request from core, core is expected to respect o_full
  assign accept = (i_mem_rd | i_mem_wr) & ~o_full;
  assign issue  = o_issue_valid;
  assign retire = o_ret_valid;

  // next occupancy, accept and retire may share an edge
  assign count_nxt    = count + CW'(accept) - CW'(retire);
  // entries accepted but not yet sent to memory
  assign unissued_nxt = unissued + CW'(accept) - CW'(issue);

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr  <= '0;
      issue_ptr <= '0;
      head_ptr  <= '0;
      count     <= '0;
      unissued  <= '0;
      state     <= IDLE;
    end else begin
      if (accept) begin
        tail_ptr <= ptr_inc(tail_ptr);
      end
      if (issue) begin
        issue_ptr <= ptr_inc(issue_ptr);
      end
      if (retire) begin
        head_ptr <= ptr_inc(head_ptr);
      end
      count    <= count_nxt;
      unissued <= unissued_nxt;
      state    <= state_nxt;
    end
  end

  // state follows what the counters will hold after this edge
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (unissued_nxt != '0) begin
          state_nxt = ACTIVE;
        end
      end
      ACTIVE: begin
        if (count_nxt == '0) begin
          state_nxt = IDLE;
        end else if (unissued_nxt == '0) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        // new request arrived while waiting on answers
        if (unissued_nxt != '0) begin
          state_nxt = ACTIVE;
        end else if (count_nxt == '0) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // memory stall holds the issue pointer
  assign o_issue_valid = (state == ACTIVE) & ~i_stall;

  // head retires as soon as its answer is in, no core back-pressure
  assign o_ret_valid = (count != '0) & i_head_done;

  assign o_alloc    = accept;
  assign o_tail_id  = tail_ptr;
  assign o_issue_id = issue_ptr;
  assign o_head_id  = head_ptr;
  assign o_full     = (count == CW'(DEPTH));
  assign o_empty    = (count == '0);

  // occupancy bounded by the ring size
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= CW'(DEPTH))
    else $error("lsq_ctrl: occupancy above queue depth");

  // core may not strobe a request while the queue is full
  a_no_accept_full: assert property (@(posedge clk) disable iff (rst)
    o_full |-> !(i_mem_rd || i_mem_wr))
    else $error("lsq_ctrl: request strobed while full");

endmodule

// File: hw/lsq/lsq_entry_store.sv
// queue entry arrays with allocate, memory completion and issue/head read ports
`timescale 1ns/10ps

module lsq_entry_store import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH
) (
  input  logic    clk,
  input  logic    rst,
  // allocate port, written on the accept edge
  input  logic    i_alloc,
  input  lsq_id_t i_tail_id,
  input  lsq_id_t i_issue_id,
  input  lsq_id_t i_head_id,
  input  addr_t   i_addr,
  input  word_t   i_wdata,
  input  dest_t   i_dest,
  input  logic    i_is_store,
  // completion port from memory
  input  logic    i_cpl_valid,
  input  lsq_id_t i_cpl_id,
  input  word_t   i_cpl_data,
  // issue read port
  output addr_t   o_issue_addr,
  output word_t   o_issue_data,
  output logic    o_issue_store,
  // head read port
  output logic    o_head_done,
  output word_t   o_ret_data,
  output dest_t   o_ret_dest,
  output logic    o_ret_store
);

  // per-slot payload
  addr_t addr_q [DEPTH];
  // holds store data until issue, then the memory answer
  word_t data_q [DEPTH];
  dest_t dest_q [DEPTH];
  logic [DEPTH-1:0] store_q;

  // answer received for this slot
  logic [DEPTH-1:0] done_q;

  // request fields written once, data replaced on completion
  always_ff @(posedge clk) begin
    if (i_alloc) begin
      addr_q[i_tail_id]  <= i_addr;
      dest_q[i_tail_id]  <= i_dest;
      store_q[i_tail_id] <= i_is_store;
      data_q[i_tail_id]  <= i_wdata;
    end
    // a store answers with zero, which is what the core sees on retire
    if (i_cpl_valid) begin
      data_q[i_cpl_id] <= i_cpl_data;
    end
  end

  // done bits
  // alloc clears, completion sets
  // never the same slot on one edge since a fresh slot is not yet issued
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= '0;
    end else begin
      if (i_alloc) begin
        done_q[i_tail_id] <= 1'b0;
      end
      if (i_cpl_valid) begin
        done_q[i_cpl_id] <= 1'b1;
      end
    end
  end

  // issue side reads the slot under the issue pointer
  assign o_issue_addr  = addr_q[i_issue_id];
  assign o_issue_data  = data_q[i_issue_id];
  assign o_issue_store = store_q[i_issue_id];

  // head side, done visible the cycle after the answer lands
  assign o_head_done = done_q[i_head_id];
  assign o_ret_data  = data_q[i_head_id];
  assign o_ret_dest  = dest_q[i_head_id];
  assign o_ret_store = store_q[i_head_id];

  // memory answers each issued slot exactly once
  a_single_cpl: assert property (@(posedge clk) disable iff (rst)
    i_cpl_valid |-> !done_q[i_cpl_id])
    else $error("lsq_entry_store: second completion for slot %0d", i_cpl_id);

  // an answer never lands on the slot being handed out
  a_cpl_not_alloc: assert property (@(posedge clk) disable iff (rst)
    (i_cpl_valid && i_alloc) |-> (i_cpl_id != i_tail_id))
    else $error("lsq_entry_store: completion hits slot under allocation");

endmodule

// File: hw/data_mem/data_mem.sv
// word data memory with parity-based latency, three-stage completion line and stall
`timescale 1ns/10ps

module data_mem import lsq_pkg::*; #(
  parameter int WORDS = MEM_WORDS
) (
  input  logic    clk,
  input  logic    rst,
  // request from the queue, one cycle strobe
  input  logic    i_valid,
  input  logic    i_store,
  input  addr_t   i_addr,
  input  word_t   i_wdata,
  input  lsq_id_t i_id,
  // no request accepted while high
  output logic    o_stall,
  // completion, one per request
  output logic    o_cpl_valid,
  output lsq_id_t o_cpl_id,
  output word_t   o_cpl_data
);

  localparam int IW = $clog2(WORDS);

  word_t mem [WORDS];

  logic [IW-1:0] word_idx;
  logic          odd_word;
  word_t         result;

  // completion line, stage 2 is the output stage
  logic [2:0] stg_vld;
  lsq_id_t    stg_id [3];
  word_t      stg_data [3];

  // word index from address bits 11..2
  assign word_idx = IW'(i_addr[11:2] % WORDS);
  // odd words answer fast, even words slow
  assign odd_word = word_idx[0];

  // store answers zero, load answers the current word
  assign result = i_store ? '0 : mem[word_idx];

  // every word starts out holding its own index
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= word_t'(i);
      end
    end else if (i_valid && i_store) begin
      mem[word_idx] <= i_wdata;
    end
  end

  // valid bits
  // even requests enter at stage 0, odd ones jump to stage 2
  always_ff @(posedge clk) begin
    if (rst) begin
      stg_vld <= '0;
    end else begin
      stg_vld[0] <= i_valid & ~odd_word;
      stg_vld[1] <= stg_vld[0];
      stg_vld[2] <= stg_vld[1] | (i_valid & odd_word);
    end
  end

  // id and data ride along with the valid bits
  always_ff @(posedge clk) begin
    stg_id[0]   <= i_id;
    stg_data[0] <= result;
    stg_id[1]   <= stg_id[0];
    stg_data[1] <= stg_data[0];
    if (i_valid && odd_word) begin
      stg_id[2]   <= i_id;
      stg_data[2] <= result;
    end else begin
      stg_id[2]   <= stg_id[1];
      stg_data[2] <= stg_data[1];
    end
  end

  // an odd request would collide with whatever sits in stage 1
  // stage 1 is itself a register so the stall is registered too
  assign o_stall = stg_vld[1];

  assign o_cpl_valid = stg_vld[2];
  assign o_cpl_id    = stg_id[2];
  assign o_cpl_data  = stg_data[2];

  // queue must hold off while memory stalls
  a_no_req_stall: assert property (@(posedge clk) disable iff (rst)
    o_stall |-> !i_valid)
    else $error("data_mem: request while stalled");

endmodule

// File: hw/lsq_top.sv
// load/store queue top level with control, entry arrays and data memory
`timescale 1ns/10ps

module lsq_top import lsq_pkg::*; #(
  parameter int DEPTH = LSQ_DEPTH,
  parameter int WORDS = MEM_WORDS
) (
  input  logic  clk,
  input  logic  rst,
  // core request side
  input  logic  i_mem_rd,
  input  logic  i_mem_wr,
  input  addr_t i_addr,
  input  word_t i_wdata,
  input  dest_t i_dest,
  // core retire side
  output logic  o_ret_valid,
  output word_t o_ret_data,
  output dest_t o_ret_dest,
  output logic  o_ret_store,
  output logic  o_full,
  output logic  o_empty
);

  // control to entry store
  logic    alloc;
  lsq_id_t tail_id;
  lsq_id_t issue_id;
  lsq_id_t head_id;
  logic    head_done;

  // issue path towards memory
  logic    issue_valid;
  addr_t   issue_addr;
  word_t   issue_data;
  logic    issue_store;
  logic    mem_stall;

  // completion path back from memory
  logic    cpl_valid;
  lsq_id_t cpl_id;
  word_t   cpl_data;

  lsq_ctrl #(
    .DEPTH(DEPTH)
  ) u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_mem_rd     (i_mem_rd),
    .i_mem_wr     (i_mem_wr),
    .i_head_done  (head_done),
    .i_stall      (mem_stall),
    .o_alloc      (alloc),
    .o_tail_id    (tail_id),
    .o_issue_id   (issue_id),
    .o_head_id    (head_id),
    .o_issue_valid(issue_valid),
    .o_ret_valid  (o_ret_valid),
    .o_full       (o_full),
    .o_empty      (o_empty)
  );

  // store flag of a new entry comes straight from the write strobe
  lsq_entry_store #(
    .DEPTH(DEPTH)
  ) u_entries (
    .clk          (clk),
    .rst          (rst),
    .i_alloc      (alloc),
    .i_tail_id    (tail_id),
    .i_issue_id   (issue_id),
    .i_head_id    (head_id),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_dest       (i_dest),
    .i_is_store   (i_mem_wr),
    .i_cpl_valid  (cpl_valid),
    .i_cpl_id     (cpl_id),
    .i_cpl_data   (cpl_data),
    .o_issue_addr (issue_addr),
    .o_issue_data (issue_data),
    .o_issue_store(issue_store),
    .o_head_done  (head_done),
    .o_ret_data   (o_ret_data),
    .o_ret_dest   (o_ret_dest),
    .o_ret_store  (o_ret_store)
  );

  // issue id doubles as the memory request id
  data_mem #(
    .WORDS(WORDS)
  ) u_dmem (
    .clk        (clk),
    .rst        (rst),
    .i_valid    (issue_valid),
    .i_store    (issue_store),
    .i_addr     (issue_addr),
    .i_wdata    (issue_data),
    .i_id       (issue_id),
    .o_stall    (mem_stall),
    .o_cpl_valid(cpl_valid),
    .o_cpl_id   (cpl_id),
    .o_cpl_data (cpl_data)
  );

endmodule

// File: dv/lsq_tb_model.svh
// xorshift generator, reference memory, retire-order model and value compare for the lsq testbench
`ifndef LSQ_TB_MODEL_SVH
`define LSQ_TB_MODEL_SVH

// one 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// reference memory, every word starts at its own index
word_t model_mem [MEM_WORDS];

// expected retire stream, oldest request at the front
word_t exp_data_q[$];
dest_t exp_dest_q[$];
logic  exp_store_q[$];

// requests held by the queue as the model sees them
int    model_cnt;

task automatic model_reset();
  for (int i = 0; i < MEM_WORDS; i++) begin
    model_mem[i] = word_t'(i);
  end
  exp_data_q.delete();
  exp_dest_q.delete();
  exp_store_q.delete();
  model_cnt = 0;
endtask

// stops the run at the first mismatch
task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
    stop_with_failure($sformatf("value mismatch on %s", name));
  end
endtask

// memory executes in program order, so a load sees all older stores
task automatic model_accept(input logic is_store, input addr_t addr, input word_t wdata,
                            input dest_t dest);
  int idx;
  idx = int'(addr[11:2]) % MEM_WORDS;
  if (is_store) begin
    model_mem[idx] = wdata;
    // stores come back as zero
    exp_data_q.push_back('0);
  end else begin
    exp_data_q.push_back(model_mem[idx]);
  end
  exp_dest_q.push_back(dest);
  exp_store_q.push_back(is_store);
  model_cnt++;
endtask

// one retire pulse against the oldest expected result
task automatic model_retire(input word_t data, input dest_t dest, input logic is_store);
  word_t e_data;
  dest_t e_dest;
  logic  e_store;
  if (exp_data_q.size() == 0) begin
    stop_with_failure("retire pulse seen with no request outstanding");
  end else begin
    e_data  = exp_data_q.pop_front();
    e_dest  = exp_dest_q.pop_front();
    e_store = exp_store_q.pop_front();
    compare("o_ret_data", data, e_data);
    compare("o_ret_dest", 32'(dest), 32'(e_dest));
    compare("o_ret_store", 32'(is_store), 32'(e_store));
    model_cnt--;
  end
endtask

`endif

// File: dv/lsq_tb.sv
// testbench for the load/store queue with random requests checked against a reference model
`timescale 1ns/10ps

module lsq_tb import lsq_pkg::*; ();

  localparam logic [31:0] SEED = 32'hfc8d30d7;
  localparam int FULL_TIMEOUT  = 500;
  localparam int DRAIN_TIMEOUT = 1000;
  localparam int ROUNDS        = 40;

  logic  clk;
  logic  rst;
  logic  i_mem_rd;
  logic  i_mem_wr;
  addr_t i_addr;
  word_t i_wdata;
  dest_t i_dest;
  logic  o_ret_valid;
  word_t o_ret_data;
  dest_t o_ret_dest;
  logic  o_ret_store;
  logic  o_full;
  logic  o_empty;

  // random state and monitor enable
  logic [31:0] rng;
  logic        mon_en;

  `include "lsq_tb_model.svh"

  lsq_top #(
    .DEPTH(LSQ_DEPTH),
    .WORDS(MEM_WORDS)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .i_mem_rd   (i_mem_rd),
    .i_mem_wr   (i_mem_wr),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_dest     (i_dest),
    .o_ret_valid(o_ret_valid),
    .o_ret_data (o_ret_data),
    .o_ret_dest (o_ret_dest),
    .o_ret_store(o_ret_store),
    .o_full     (o_full),
    .o_empty    (o_empty)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // hot set of words 16..27 mixes even and odd, rare far words stay untouched
  function automatic addr_t pick_addr(input logic [31:0] r);
    logic [9:0] idx;
    if (r[7:4] == 4'h0) begin
      idx = 10'h200 + 10'(r[24:16]);
    end else begin
      idx = 10'd16 + 10'(r[11:8] % 12);
    end
    // upper address bits do not select the word
    return {r[31:12], idx, 2'b00};
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    i_mem_rd = 1'b0;
    i_mem_wr = 1'b0;
  endtask

  // one request strobe, held back while the queue is full
  task automatic drive_request(input logic is_store, input addr_t addr, input word_t wdata,
                               input dest_t dest);
    if (o_full) begin
      drive_idle();
    end else begin
      i_addr   = addr;
      i_wdata  = wdata;
      i_dest   = dest;
      i_mem_rd = ~is_store;
      i_mem_wr = is_store;
    end
  endtask

  task automatic drive_random(input logic is_store);
    logic [31:0] r;
    r = next_rand();
    drive_request(is_store, pick_addr(r), next_rand(), dest_t'(r[3:0]));
  endtask

  // light traffic, about one request every two cycles
  task automatic sparse_phase(input int n);
    logic [31:0] r;
    repeat (n) begin
      next_cycle();
      r = next_rand();
      case (r[1:0])
        2'd2: drive_random(1'b0);
        2'd3: drive_random(1'b1);
        default: drive_idle();
      endcase
    end
  endtask

  // back to back requests until the queue reports full
  task automatic burst_phase();
    logic [31:0] r;
    int          waited;
    waited = 0;
    next_cycle();
    while (!o_full) begin
      if (waited == FULL_TIMEOUT) begin
        stop_with_failure("queue never became full during a request burst");
      end else begin
        r = next_rand();
        drive_random(r[0]);
        next_cycle();
        waited++;
      end
    end
    drive_idle();
  endtask

  // no new requests, everything outstanding must retire
  task automatic drain();
    int waited;
    waited = 0;
    next_cycle();
    drive_idle();
    while (!o_empty) begin
      if (waited == DRAIN_TIMEOUT) begin
        stop_with_failure("outstanding requests did not retire after stimulus stopped");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  // mid-cycle monitor, sees what the next rising edge will do
  always @(negedge clk) begin
    logic was_full;
    if (mon_en) begin
      was_full = (model_cnt == LSQ_DEPTH);
      compare("o_full", 32'(o_full), 32'(was_full));
      compare("o_empty", 32'(o_empty), 32'(model_cnt == 0));
      if (o_ret_valid === 1'b1) begin
        model_retire(o_ret_data, o_ret_dest, o_ret_store);
      end
      if ((i_mem_rd || i_mem_wr) && !was_full) begin
        model_accept(i_mem_wr, i_addr, i_wdata, i_dest);
      end
    end
  end

  initial begin
    logic [31:0] r;
    rst      = 1'b1;
    i_mem_rd = 1'b0;
    i_mem_wr = 1'b0;
    i_addr   = '0;
    i_wdata  = '0;
    i_dest   = '0;
    rng      = SEED;
    mon_en   = 1'b0;
    model_reset();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    compare("o_ret_valid", 32'(o_ret_valid), 32'h0);
    compare("o_full", 32'(o_full), 32'h0);
    compare("o_empty", 32'(o_empty), 32'h1);
    mon_en = 1'b1;
    // store then load of one word, then a load of a word nobody wrote
    next_cycle();
    drive_request(1'b1, 32'h0000_0050, 32'hdead_beef, 4'h1);
    next_cycle();
    drive_request(1'b0, 32'h0000_0050, 32'h0, 4'h2);
    next_cycle();
    drive_request(1'b0, 32'h0000_0af0, 32'h0, 4'h3);
    next_cycle();
    drive_idle();
    burst_phase();
    for (int k = 0; k < ROUNDS; k++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        burst_phase();
      end else begin
        sparse_phase(16 + int'(r[7:3]));
      end
    end
    drain();
    @(negedge clk);
    compare("order queue size", 32'(exp_data_q.size()), 32'h0);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+dv
common/lsq_pkg.sv
hw/lsq/lsq_ctrl.sv
hw/lsq/lsq_entry_store.sv
hw/data_mem/data_mem.sv
hw/lsq_top.sv
dv/lsq_tb.sv
